//--- regif_reg_pkg.sv
// register map, widths and timer constants shared by the host register interface RTL
package regif_reg_pkg;

    typedef logic [15:0] word_t;      // register or memory word
    typedef logic [7:0]  byte_t;      // host bus byte
    typedef logic [15:0] addr_t;      // memory address
    typedef logic [3:0]  reg_num_t;   // host register number

    // host visible register numbers
    localparam reg_num_t REG_SYS_CTRL = 4'd0;
    localparam reg_num_t REG_INT_CTRL = 4'd1;
    localparam reg_num_t REG_TIMER    = 4'd2;
    localparam reg_num_t REG_RD_XADDR = 4'd3;
    localparam reg_num_t REG_WR_XADDR = 4'd4;
    localparam reg_num_t REG_XDATA    = 4'd5;
    localparam reg_num_t REG_RD_INCR  = 4'd6;
    localparam reg_num_t REG_RD_ADDR  = 4'd7;
    localparam reg_num_t REG_WR_INCR  = 4'd8;
    localparam reg_num_t REG_WR_ADDR  = 4'd9;
    localparam reg_num_t REG_DATA     = 4'd10;
    localparam reg_num_t REG_DATA_2   = 4'd11;

    // slow clock for simulation so the timer moves
    localparam int PCLK_HZ      = 200_000;
    localparam int TIMER_DIV    = PCLK_HZ / 10_000;   // cycles per 0.1 ms tick
    localparam int TIMER_FRAC_W = $clog2(TIMER_DIV);
    localparam int INTR_W       = 4;

    // one byte transaction on the host bus
    typedef struct packed {
        logic     wr;     // 1 = write, 0 = read
        reg_num_t num;
        logic     odd;    // 0 = even/high byte, 1 = odd/low byte
        byte_t    data;
    } host_req_t;

    // register byte write handed to the register block
    typedef struct packed {
        reg_num_t num;
        logic     odd;
        byte_t    data;
        byte_t    even;   // staged even byte, completes the word on odd writes
    } reg_wr_t;

endpackage

//--- regif_mem_pkg.sv
// request and busy-state types for the VRAM and XR memory channels
package regif_mem_pkg;

    // VRAM access with nibble write mask
    typedef struct packed {
        logic                  wr;
        regif_reg_pkg::addr_t  addr;
        regif_reg_pkg::word_t  data;
        logic [3:0]            mask;   // one bit per nibble, msb = bits 15..12
    } vram_req_t;

    // extended register bus access
    typedef struct packed {
        logic                  wr;
        regif_reg_pkg::addr_t  addr;
        regif_reg_pkg::word_t  data;
    } xr_req_t;

    // channel busy flags as seen by the host port
    typedef struct packed {
        logic vram_busy;
        logic xr_busy;
    } mem_state_t;

endpackage

//--- host_byte_port.sv
// host bus side of the register interface; accepts byte transactions and returns read bytes
`timescale 1ns/1ps

module host_byte_port (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      host_valid_i,
    input  regif_reg_pkg::host_req_t  host_req_i,
    output logic                      host_ready_o,
    output regif_reg_pkg::byte_t      host_rdata_o,
    output logic                      host_rvalid_o,
    input  regif_mem_pkg::mem_state_t mem_state_i,
    input  regif_reg_pkg::word_t      rd_word_i,
    output logic                      wr_stb_o,
    output regif_reg_pkg::reg_wr_t    wr_o,
    output logic                      rd_stb_o,
    output regif_reg_pkg::reg_num_t   rd_reg_o,
    output logic                      rd_odd_o
);
    import regif_reg_pkg::*;

    logic  run_q;        // low through reset, high from the first cycle after
    logic  need_vram;
    logic  need_xr;
    logic  blocked;
    logic  accept;
    byte_t xdata_even;   // staged high byte of XDATA
    byte_t data_even;    // staged high byte of DATA and DATA_2

    // odd bytes of these registers start or depend on a memory access
    always_comb begin
        need_vram = 1'b0;
        need_xr   = 1'b0;
        if (host_req_i.odd) begin
            case (host_req_i.num)
                REG_XDATA, REG_RD_XADDR:          need_xr   = 1'b1;
                REG_DATA, REG_DATA_2, REG_RD_ADDR: need_vram = 1'b1;
                default: ;
            endcase
        end
    end

    assign blocked      = (need_vram && mem_state_i.vram_busy) ||
                          (need_xr && mem_state_i.xr_busy);
    assign host_ready_o = run_q && !blocked;
    assign accept       = host_valid_i && host_ready_o;

    assign wr_stb_o = accept && host_req_i.wr;
    assign rd_stb_o = accept && !host_req_i.wr;
    assign rd_reg_o = host_req_i.num;
    assign rd_odd_o = host_req_i.odd;

    always_comb begin
        wr_o.num  = host_req_i.num;
        wr_o.odd  = host_req_i.odd;
        wr_o.data = host_req_i.data;
        wr_o.even = (host_req_i.num == REG_XDATA) ? xdata_even : data_even;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            run_q         <= 1'b0;
            host_rvalid_o <= 1'b0;
        end else begin
            run_q         <= 1'b1;
            host_rvalid_o <= rd_stb_o;   // response one cycle after accept
        end
    end

    always_ff @(posedge clk) begin
        if (wr_stb_o && !host_req_i.odd) begin
            if (host_req_i.num == REG_XDATA) begin
                xdata_even <= host_req_i.data;
            end
            if (host_req_i.num == REG_DATA || host_req_i.num == REG_DATA_2) begin
                data_even <= host_req_i.data;
            end
        end
        if (rd_stb_o) begin
            host_rdata_o <= host_req_i.odd ? rd_word_i[7:0] : rd_word_i[15:8];
        end
    end

endmodule

//--- reg_block.sv
// register file, timer and interrupt control; turns register events into memory requests
`timescale 1ns/1ps

module reg_block (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                wr_stb_i,
    input  regif_reg_pkg::reg_wr_t              wr_i,
    input  logic                                rd_stb_i,
    input  regif_reg_pkg::reg_num_t             rd_reg_i,
    input  logic                                rd_odd_i,
    output regif_reg_pkg::word_t                rd_word_o,
    output regif_mem_pkg::mem_state_t           mem_state_o,
    output logic                                vram_stb_o,
    output regif_mem_pkg::vram_req_t            vram_req_o,
    input  logic                                vram_busy_i,
    input  logic                                vram_done_i,
    input  regif_reg_pkg::word_t                vram_rdata_i,
    output logic                                xr_stb_o,
    output regif_mem_pkg::xr_req_t              xr_req_o,
    input  logic                                xr_busy_i,
    input  logic                                xr_done_i,
    input  regif_reg_pkg::word_t                xr_rdata_i,
    input  logic [regif_reg_pkg::INTR_W-1:0]    intr_status_i,
    output logic [regif_reg_pkg::INTR_W-1:0]    intr_mask_o,
    output logic [regif_reg_pkg::INTR_W-1:0]    intr_clear_o
);
    import regif_reg_pkg::*;

    addr_t                   rd_xaddr;
    addr_t                   wr_xaddr;
    word_t                   xdata;        // last word read from XR
    word_t                   rd_incr;
    addr_t                   rd_addr;
    word_t                   wr_incr;
    addr_t                   wr_addr;
    word_t                   data;         // last word read from VRAM
    logic [3:0]              wr_mask;
    word_t                   timer;
    logic [TIMER_FRAC_W-1:0] timer_frac;
    byte_t                   timer_latch;  // low byte frozen on high byte read
    logic                    vram_rd_q;    // pending VRAM access is a read
    logic                    xr_rd_q;
    word_t                   wr_word;

    // replace the even or odd byte of a word
    function automatic word_t put_byte(word_t w, logic odd, byte_t b);
        return odd ? {w[15:8], b} : {b, w[7:0]};
    endfunction

    assign wr_word = {wr_i.even, wr_i.data};
    assign mem_state_o.vram_busy = vram_busy_i;
    assign mem_state_o.xr_busy   = xr_busy_i;

    always_comb begin
        case (rd_reg_i)
            REG_SYS_CTRL: rd_word_o = {vram_busy_i | xr_busy_i, 11'b0, wr_mask};
            REG_INT_CTRL: rd_word_o = {4'b0, intr_mask_o, 4'b0, intr_status_i};
            REG_TIMER:    rd_word_o = {timer[15:8], timer_latch};
            REG_RD_XADDR: rd_word_o = rd_xaddr;
            REG_WR_XADDR: rd_word_o = wr_xaddr;
            REG_XDATA:    rd_word_o = xdata;
            REG_RD_INCR:  rd_word_o = rd_incr;
            REG_RD_ADDR:  rd_word_o = rd_addr;
            REG_WR_INCR:  rd_word_o = wr_incr;
            REG_WR_ADDR:  rd_word_o = wr_addr;
            REG_DATA, REG_DATA_2: rd_word_o = data;
            default:      rd_word_o = '0;
        endcase
    end

    // VRAM request: data write, read address pre-read, or next read after DATA
    always_comb begin
        vram_req_o.wr   = 1'b0;
        vram_req_o.addr = rd_addr;
        vram_req_o.data = wr_word;
        vram_req_o.mask = wr_mask;
        vram_stb_o      = 1'b0;
        if (wr_stb_i && wr_i.odd && (wr_i.num == REG_DATA || wr_i.num == REG_DATA_2)) begin
            vram_stb_o      = 1'b1;
            vram_req_o.wr   = 1'b1;
            vram_req_o.addr = wr_addr;
        end else if (wr_stb_i && wr_i.odd && wr_i.num == REG_RD_ADDR) begin
            vram_stb_o      = 1'b1;
            vram_req_o.addr = {rd_addr[15:8], wr_i.data};
        end else if (rd_stb_i && rd_odd_i && (rd_reg_i == REG_DATA || rd_reg_i == REG_DATA_2)) begin
            vram_stb_o      = 1'b1;
        end
    end

    always_comb begin
        xr_req_o.wr   = 1'b0;
        xr_req_o.addr = rd_xaddr;
        xr_req_o.data = wr_word;
        xr_stb_o      = 1'b0;
        if (wr_stb_i && wr_i.odd && wr_i.num == REG_XDATA) begin
            xr_stb_o      = 1'b1;
            xr_req_o.wr   = 1'b1;
            xr_req_o.addr = wr_xaddr;
        end else if (wr_stb_i && wr_i.odd && wr_i.num == REG_RD_XADDR) begin
            xr_stb_o      = 1'b1;
            xr_req_o.addr = {rd_xaddr[15:8], wr_i.data};
        end else if (rd_stb_i && rd_odd_i && rd_reg_i == REG_XDATA) begin
            xr_stb_o      = 1'b1;
        end
    end

    // free running 0.1 ms timer
    always_ff @(posedge clk) begin
        if (reset_i) begin
            timer      <= '0;
            timer_frac <= '0;
        end else if (timer_frac == TIMER_FRAC_W'(TIMER_DIV - 1)) begin
            timer_frac <= '0;
            timer      <= timer + 16'd1;
        end else begin
            timer_frac <= timer_frac + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_xaddr     <= '0;
            wr_xaddr     <= '0;
            xdata        <= '0;
            rd_incr      <= '0;
            rd_addr      <= '0;
            wr_incr      <= '0;
            wr_addr      <= '0;
            data         <= '0;
            wr_mask      <= 4'hF;
            intr_mask_o  <= '0;
            intr_clear_o <= '0;
            timer_latch  <= '0;
            vram_rd_q    <= 1'b0;
            xr_rd_q      <= 1'b0;
        end else begin
            intr_clear_o <= '0;   // one cycle strobe
            if (vram_done_i) begin
                if (vram_rd_q) begin
                    data    <= vram_rdata_i;
                    rd_addr <= rd_addr + rd_incr;
                end else begin
                    wr_addr <= wr_addr + wr_incr;
                end
            end
            if (xr_done_i) begin
                if (xr_rd_q) begin
                    xdata    <= xr_rdata_i;
                    rd_xaddr <= rd_xaddr + 16'd1;
                end else begin
                    wr_xaddr <= wr_xaddr + 16'd1;
                end
            end
            if (vram_stb_o) begin
                vram_rd_q <= !vram_req_o.wr;
            end
            if (xr_stb_o) begin
                xr_rd_q <= !xr_req_o.wr;
            end
            if (rd_stb_i && !rd_odd_i && rd_reg_i == REG_TIMER) begin
                timer_latch <= timer[7:0];
            end
            // host writes win over a same cycle increment
            if (wr_stb_i) begin
                case (wr_i.num)
                    REG_SYS_CTRL: if (wr_i.odd) wr_mask <= wr_i.data[3:0];
                    REG_INT_CTRL: begin
                        if (wr_i.odd) begin
                            intr_clear_o <= wr_i.data[INTR_W-1:0];
                        end else begin
                            intr_mask_o  <= wr_i.data[INTR_W-1:0];
                        end
                    end
                    REG_RD_XADDR: rd_xaddr <= put_byte(rd_xaddr, wr_i.odd, wr_i.data);
                    REG_WR_XADDR: wr_xaddr <= put_byte(wr_xaddr, wr_i.odd, wr_i.data);
                    REG_RD_INCR:  rd_incr  <= put_byte(rd_incr, wr_i.odd, wr_i.data);
                    REG_RD_ADDR:  rd_addr  <= put_byte(rd_addr, wr_i.odd, wr_i.data);
                    REG_WR_INCR:  wr_incr  <= put_byte(wr_incr, wr_i.odd, wr_i.data);
                    REG_WR_ADDR:  wr_addr  <= put_byte(wr_addr, wr_i.odd, wr_i.data);
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- mem_channel.sv
// one memory request channel; holds a request until acknowledged and returns the read word
`timescale 1ns/1ps

module mem_channel #(
    parameter type req_t = logic
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  start_i,
    input  req_t                  req_i,
    output logic                  busy_o,
    output logic                  done_o,
    output regif_reg_pkg::word_t  rdata_o,
    output logic                  req_valid_o,
    output req_t                  req_o,
    input  logic                  ack_i,
    input  regif_reg_pkg::word_t  mem_rdata_i
);

    logic take;
    logic fin;

    assign take   = start_i && !busy_o;
    assign fin    = req_valid_o && ack_i;   // ack is the ready of the memory
    // stays busy through done so the owner can update addresses first
    assign busy_o = req_valid_o || done_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_valid_o <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            done_o <= fin;
            if (fin) begin
                req_valid_o <= 1'b0;
            end else if (take) begin
                req_valid_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_o <= req_i;   // held steady while valid
        end
        if (fin) begin
            rdata_o <= mem_rdata_i;
        end
    end

endmodule

//--- regif_top.sv
// top of the host register interface; connects host port, register block and memory channels
`timescale 1ns/1ps

module regif_top (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                host_valid_i,
    input  regif_reg_pkg::host_req_t            host_req_i,
    output logic                                host_ready_o,
    output regif_reg_pkg::byte_t                host_rdata_o,
    output logic                                host_rvalid_o,
    output logic                                vram_valid_o,
    output regif_mem_pkg::vram_req_t            vram_req_o,
    input  logic                                vram_ack_i,
    input  regif_reg_pkg::word_t                vram_rdata_i,
    output logic                                xr_valid_o,
    output regif_mem_pkg::xr_req_t              xr_req_o,
    input  logic                                xr_ack_i,
    input  regif_reg_pkg::word_t                xr_rdata_i,
    input  logic [regif_reg_pkg::INTR_W-1:0]    intr_status_i,
    output logic [regif_reg_pkg::INTR_W-1:0]    intr_mask_o,
    output logic [regif_reg_pkg::INTR_W-1:0]    intr_clear_o
);
    import regif_reg_pkg::*;
    import regif_mem_pkg::*;

    logic       wr_stb;
    reg_wr_t    wr;
    logic       rd_stb;
    reg_num_t   rd_reg;
    logic       rd_odd;
    word_t      rd_word;
    mem_state_t mem_state;
    logic       vram_stb;
    vram_req_t  vram_req;
    logic       vram_busy;
    logic       vram_done;
    word_t      vram_word;   // read word latched by the VRAM channel
    logic       xr_stb;
    xr_req_t    xr_req;
    logic       xr_busy;
    logic       xr_done;
    word_t      xr_word;

    host_byte_port i_host_byte_port (
        .clk           (clk),
        .reset_i       (reset_i),
        .host_valid_i  (host_valid_i),
        .host_req_i    (host_req_i),
        .host_ready_o  (host_ready_o),
        .host_rdata_o  (host_rdata_o),
        .host_rvalid_o (host_rvalid_o),
        .mem_state_i   (mem_state),
        .rd_word_i     (rd_word),
        .wr_stb_o      (wr_stb),
        .wr_o          (wr),
        .rd_stb_o      (rd_stb),
        .rd_reg_o      (rd_reg),
        .rd_odd_o      (rd_odd)
    );

    reg_block i_reg_block (
        .clk           (clk),
        .reset_i       (reset_i),
        .wr_stb_i      (wr_stb),
        .wr_i          (wr),
        .rd_stb_i      (rd_stb),
        .rd_reg_i      (rd_reg),
        .rd_odd_i      (rd_odd),
        .rd_word_o     (rd_word),
        .mem_state_o   (mem_state),
        .vram_stb_o    (vram_stb),
        .vram_req_o    (vram_req),
        .vram_busy_i   (vram_busy),
        .vram_done_i   (vram_done),
        .vram_rdata_i  (vram_word),
        .xr_stb_o      (xr_stb),
        .xr_req_o      (xr_req),
        .xr_busy_i     (xr_busy),
        .xr_done_i     (xr_done),
        .xr_rdata_i    (xr_word),
        .intr_status_i (intr_status_i),
        .intr_mask_o   (intr_mask_o),
        .intr_clear_o  (intr_clear_o)
    );

    mem_channel #(.req_t(vram_req_t)) i_vram_channel (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (vram_stb),
        .req_i       (vram_req),
        .busy_o      (vram_busy),
        .done_o      (vram_done),
        .rdata_o     (vram_word),
        .req_valid_o (vram_valid_o),
        .req_o       (vram_req_o),
        .ack_i       (vram_ack_i),
        .mem_rdata_i (vram_rdata_i)
    );

    mem_channel #(.req_t(xr_req_t)) i_xr_channel (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (xr_stb),
        .req_i       (xr_req),
        .busy_o      (xr_busy),
        .done_o      (xr_done),
        .rdata_o     (xr_word),
        .req_valid_o (xr_valid_o),
        .req_o       (xr_req_o),
        .ack_i       (xr_ack_i),
        .mem_rdata_i (xr_rdata_i)
    );

endmodule

//--- tb_mem_responder.sv
// behavioural VRAM and XR memories for the testbench; acknowledge after a random delay
`timescale 1ns/1ps

module tb_mem_responder (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      vram_valid_i,
    input  regif_mem_pkg::vram_req_t  vram_req_i,
    output logic                      vram_ack_o,
    output regif_reg_pkg::word_t      vram_rdata_o,
    input  logic [1:0]                vram_dly_i,
    input  logic                      xr_valid_i,
    input  regif_mem_pkg::xr_req_t    xr_req_i,
    output logic                      xr_ack_o,
    output regif_reg_pkg::word_t      xr_rdata_o,
    input  logic [1:0]                xr_dly_i
);
    import regif_reg_pkg::*;

    word_t      vram [256];
    word_t      xr [256];
    logic [1:0] vram_cnt, vram_dly_q;
    logic [1:0] xr_cnt, xr_dly_q;
    word_t      nib_mask;

    initial begin
        for (int i = 0; i < 256; i++) begin
            vram[i] = {i[7:0], ~i[7:0]} ^ 16'h3c5a;   // pattern over the whole index
            xr[i]   = {~i[7:0], i[7:0]} ^ 16'h0f0f;
        end
    end

    assign nib_mask     = {{4{vram_req_i.mask[3]}}, {4{vram_req_i.mask[2]}},
                           {4{vram_req_i.mask[1]}}, {4{vram_req_i.mask[0]}}};
    assign vram_ack_o   = vram_valid_i && (vram_cnt >= vram_dly_q);
    assign xr_ack_o     = xr_valid_i && (xr_cnt >= xr_dly_q);
    assign vram_rdata_o = vram[vram_req_i.addr[7:0]];
    assign xr_rdata_o   = xr[xr_req_i.addr[7:0]];

    always @(posedge clk) begin
        if (reset_i || !vram_valid_i || vram_ack_o) begin
            vram_cnt   <= '0;
            vram_dly_q <= vram_dly_i;   // delay for the next request
        end else begin
            vram_cnt <= vram_cnt + 2'd1;
        end
        if (reset_i || !xr_valid_i || xr_ack_o) begin
            xr_cnt   <= '0;
            xr_dly_q <= xr_dly_i;
        end else begin
            xr_cnt <= xr_cnt + 2'd1;
        end
        if (vram_ack_o && vram_req_i.wr) begin
            vram[vram_req_i.addr[7:0]] <= (vram[vram_req_i.addr[7:0]] & ~nib_mask) |
                                          (vram_req_i.data & nib_mask);
        end
        if (xr_ack_o && xr_req_i.wr) begin
            xr[xr_req_i.addr[7:0]] <= xr_req_i.data;
        end
    end

endmodule

//--- tb_regif_properties.sv
// concurrent checks on the host handshake and both memory channels, bound into the DUT top
`timescale 1ns/1ps

module tb_regif_properties (
    input logic                      clk,
    input logic                      reset_i,
    input logic                      rd_accept,
    input logic                      host_rvalid_o,
    input logic                      vram_valid_o,
    input regif_mem_pkg::vram_req_t  vram_req_o,
    input logic                      vram_ack_i,
    input logic                      vram_stb,
    input logic                      vram_busy,
    input logic                      xr_valid_o,
    input regif_mem_pkg::xr_req_t    xr_req_o,
    input logic                      xr_ack_i,
    input logic                      xr_stb,
    input logic                      xr_busy
);

    rvalid_after_read: assert property (@(posedge clk) disable iff (reset_i)
        rd_accept |=> host_rvalid_o) else $error("read response missing");

    rvalid_only_after_read: assert property (@(posedge clk) disable iff (reset_i)
        host_rvalid_o |-> $past(rd_accept)) else $error("read response without read");

    vram_req_stable: assert property (@(posedge clk) disable iff (reset_i)
        vram_valid_o && !vram_ack_i |=> vram_valid_o && $stable(vram_req_o))
        else $error("VRAM request changed before ack");

    xr_req_stable: assert property (@(posedge clk) disable iff (reset_i)
        xr_valid_o && !xr_ack_i |=> xr_valid_o && $stable(xr_req_o))
        else $error("XR request changed before ack");

    no_start_while_busy: assert property (@(posedge clk) disable iff (reset_i)
        !(vram_stb && vram_busy) && !(xr_stb && xr_busy))
        else $error("request started on a busy channel");

endmodule

bind regif_top tb_regif_properties i_regif_properties (
    .clk           (clk),
    .reset_i       (reset_i),
    .rd_accept     (host_valid_i && host_ready_o && !host_req_i.wr),
    .host_rvalid_o (host_rvalid_o),
    .vram_valid_o  (vram_valid_o),
    .vram_req_o    (vram_req_o),
    .vram_ack_i    (vram_ack_i),
    .vram_stb      (vram_stb),
    .vram_busy     (vram_busy),
    .xr_valid_o    (xr_valid_o),
    .xr_req_o      (xr_req_o),
    .xr_ack_i      (xr_ack_i),
    .xr_stb        (xr_stb),
    .xr_busy       (xr_busy)
);

//--- tb_regif.sv
// testbench top; random register traffic through the host port, checked against a model
`timescale 1ns/1ps

module tb_regif;
    import regif_reg_pkg::*;
    import regif_mem_pkg::*;

    localparam int TIMEOUT = 200;   // cycles per wait
    localparam int N       = 8;     // words per stream

    logic clk, reset_i, host_valid_i, host_ready_o, host_rvalid_o;
    host_req_t  host_req_i;
    byte_t      host_rdata_o;
    logic       vram_valid_o, vram_ack_i, xr_valid_o, xr_ack_i;
    vram_req_t  vram_req_o;
    xr_req_t    xr_req_o;
    word_t      vram_rdata_i, xr_rdata_i;
    logic [3:0] intr_status_i, intr_mask_o, intr_clear_o;
    logic [3:0] dly_bits;
    logic [31:0] stim_lfsr, dly_lfsr;
    word_t      vram_m [256];   // model mirrors of both memories
    word_t      xr_m [256];
    int         errors, tests, errs0, cyc;
    reg_num_t   plain_regs [4];

    regif_top i_regif_top (.*);

    tb_mem_responder i_mem (
        .clk(clk), .reset_i(reset_i),
        .vram_valid_i(vram_valid_o), .vram_req_i(vram_req_o), .vram_ack_o(vram_ack_i),
        .vram_rdata_o(vram_rdata_i), .vram_dly_i(dly_bits[1:0]),
        .xr_valid_i(xr_valid_o), .xr_req_i(xr_req_o), .xr_ack_o(xr_ack_i),
        .xr_rdata_o(xr_rdata_i), .xr_dly_i(dly_bits[3:2])
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r         = {r[30:0], stim_lfsr[0]};
            stim_lfsr = lfsr_next(stim_lfsr);
        end
        return r;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    always @(negedge clk) begin   // fresh ack delays every cycle
        for (int i = 0; i < 4; i++) begin
            dly_bits = {dly_bits[2:0], dly_lfsr[0]};
            dly_lfsr = lfsr_next(dly_lfsr);
        end
    end

    task automatic give_up(input string what);
        $display("timeout at %0t: no %s", $time, what);
        $display("sim failed");
        $finish;
    endtask

    task automatic check_eq(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // one byte transaction, called on a falling edge, returns on the next one
    task automatic bus_xfer(input logic wr, input reg_num_t num, input logic odd, input byte_t d);
        int t;
        host_req_i   = '{wr: wr, num: num, odd: odd, data: d};
        host_valid_i = 1'b1;
        t = 0;
        #10;
        while (!host_ready_o) begin
            t++;
            if (t > TIMEOUT) give_up("host_ready_o");
            @(negedge clk);
            #10;
        end
        @(posedge clk);
        @(negedge clk);
        host_valid_i = 1'b0;
    endtask

    task automatic read_byte(input reg_num_t num, input logic odd, output byte_t b);
        int t;
        bus_xfer(1'b0, num, odd, 8'h00);
        t = 0;
        while (!host_rvalid_o) begin
            t++;
            if (t > TIMEOUT) give_up("host_rvalid_o");
            @(negedge clk);
        end
        b = host_rdata_o;
    endtask

    task automatic write_word(input reg_num_t num, input word_t w);
        bus_xfer(1'b1, num, 1'b0, w[15:8]);
        bus_xfer(1'b1, num, 1'b1, w[7:0]);
    endtask

    task automatic read_word(input reg_num_t num, output word_t w);
        read_byte(num, 1'b0, w[15:8]);
        read_byte(num, 1'b1, w[7:0]);
    endtask

    // polls the busy bit of the system status
    task automatic wait_idle();
        byte_t b;
        int    t;
        t = 0;
        read_byte(REG_SYS_CTRL, 1'b0, b);
        while (b[7]) begin
            t++;
            if (t > TIMEOUT) give_up("end of memory busy");
            read_byte(REG_SYS_CTRL, 1'b0, b);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errs0);
        errs0 = errors;
    endtask

    initial begin
        word_t       w, a, base, inc, t1, t2;
        word_t       mexp;
        word_t       rst_exp;
        logic [31:0] r;
        logic [3:0]  m, s, c;
        int          c1, c2;
        stim_lfsr     = 32'h0bc32051;
        dly_lfsr      = 32'h0bc32051;
        dly_bits      = '0;
        errors        = 0;
        tests         = 0;
        errs0         = 0;
        cyc           = 0;
        plain_regs    = '{REG_RD_INCR, REG_WR_INCR, REG_WR_ADDR, REG_WR_XADDR};
        reset_i       = 1'b1;
        host_valid_i  = 1'b0;
        host_req_i    = '0;
        intr_status_i = '0;
        repeat (16) @(negedge clk);
        reset_i = 1'b0;
        for (int i = 0; i < 256; i++) begin
            vram_m[i] = i_mem.vram[i];
            xr_m[i]   = i_mem.xr[i];
        end

        for (int i = 0; i < 16; i++) begin
            if (i != 2) begin   // timer runs freely
                read_word(reg_num_t'(i), w);
                if (i == 0) begin
                    rst_exp = 16'h000F;
                end else if (i == 11) begin
                    // DATA low read fetched word 0, high byte taken while it was pending
                    rst_exp = {8'h00, vram_m[0][7:0]};
                end else begin
                    rst_exp = 16'h0;
                end
                check_eq($sformatf("reset value of reg %0d", i), w, rst_exp);
            end
        end
        foreach (plain_regs[i]) begin
            r = rand_bits(16);
            write_word(plain_regs[i], r[15:0]);
            read_word(plain_regs[i], w);
            check_eq($sformatf("reg %0d", plain_regs[i]), w, r[15:0]);
        end
        end_test("register readback");

        r    = rand_bits(4);
        inc  = {11'b0, r[3:0], 1'b1};   // odd step keeps low bytes distinct
        r    = rand_bits(4);
        m    = {r[3:1], ~r[3]};         // some nibbles kept, some written
        mexp = {{4{m[3]}}, {4{m[2]}}, {4{m[1]}}, {4{m[0]}}};
        r    = rand_bits(16);
        base = r[15:0];
        bus_xfer(1'b1, REG_SYS_CTRL, 1'b1, {4'b0, m});
        write_word(REG_WR_INCR, inc);
        write_word(REG_WR_ADDR, base);
        for (int k = 0; k < N; k++) begin
            r = rand_bits(16);
            a = base + inc * 16'(k);
            vram_m[a[7:0]] = (vram_m[a[7:0]] & ~mexp) | (r[15:0] & mexp);
            write_word(REG_DATA, r[15:0]);
        end
        wait_idle();
        for (int i = 0; i < 256; i++) begin
            check_eq($sformatf("vram[%0d]", i), i_mem.vram[i], vram_m[i]);
        end
        read_word(REG_WR_ADDR, w);
        check_eq("WR_ADDR", w, base + inc * 16'(N));
        end_test("VRAM write stream");

        r    = rand_bits(4);
        inc  = {11'b0, r[3:0], 1'b1};
        r    = rand_bits(16);
        base = r[15:0];
        write_word(REG_RD_INCR, inc);
        write_word(REG_RD_ADDR, base);
        for (int k = 0; k < N; k++) begin
            a = base + inc * 16'(k);
            wait_idle();
            read_word(REG_DATA, w);
            check_eq($sformatf("DATA read %0d", k), w, vram_m[a[7:0]]);
        end
        end_test("VRAM read stream");

        r    = rand_bits(16);
        base = r[15:0];
        write_word(REG_WR_XADDR, base);
        for (int k = 0; k < N; k++) begin
            r = rand_bits(16);
            a = base + 16'(k);
            xr_m[a[7:0]] = r[15:0];
            write_word(REG_XDATA, r[15:0]);
        end
        wait_idle();
        write_word(REG_RD_XADDR, base);
        for (int k = 0; k < N; k++) begin
            a = base + 16'(k);
            wait_idle();
            read_word(REG_XDATA, w);
            check_eq($sformatf("XDATA read %0d", k), w, xr_m[a[7:0]]);
        end
        end_test("XR write and read");

        r = rand_bits(4);
        s = {r[3:1], ~r[3]};   // never all zero or all one
        intr_status_i = s;
        r = rand_bits(4);
        m = {r[3:1], ~r[3]};
        bus_xfer(1'b1, REG_INT_CTRL, 1'b0, {4'b0, m});
        check_eq("intr_mask_o", {12'b0, intr_mask_o}, {12'b0, m});
        read_word(REG_INT_CTRL, w);
        check_eq("INT_CTRL", w, {4'b0, m, 4'b0, s});
        r = rand_bits(4);
        c = {r[3:1], ~r[3]};
        bus_xfer(1'b1, REG_INT_CTRL, 1'b1, {4'b0, c});
        check_eq("intr_clear_o", {12'b0, intr_clear_o}, {12'b0, c});
        @(negedge clk);
        check_eq("intr_clear_o after strobe", {12'b0, intr_clear_o}, 16'h0);
        read_word(REG_TIMER, t1);
        c1 = cyc;
        r  = rand_bits(8);
        repeat (50 + int'(r[7:0])) @(negedge clk);
        read_word(REG_TIMER, t2);
        c2 = cyc;
        if (t2 < t1) begin
            $display("FAILED at %0t: REG_TIMER is %h, expected at least %h", $time, t2, t1);
            errors++;
        end
        if (int'(t2 - t1) > (c2 - c1) / TIMER_DIV + 1) begin
            $display("FAILED at %0t: REG_TIMER is %h, expected at most %h after %0d cycles",
                     $time, t2, t1 + word_t'((c2 - c1) / TIMER_DIV + 1), c2 - c1);
            errors++;
        end
        end_test("interrupt control and timer");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- files.f
regif_reg_pkg.sv
regif_mem_pkg.sv
host_byte_port.sv
reg_block.sv
mem_channel.sv
regif_top.sv
tb_mem_responder.sv
tb_regif_properties.sv
tb_regif.sv

//--- Makefile
# Verilator build for the host register interface testbench

TOP := tb_regif

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || echo "sim failed" >> sim.log
	cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
